/* context_params.svh */
`ifndef CONTEXT_PARAMS_SVH
`define CONTEXT_PARAMS_SVH

// coefficient and sum widths
`define SAMPLE_W 16
// largest sum is 93, so eight bits are enough
`define SUM_W 8

// coded bit planes 3 to 8
`define FIRST_PLANE 3
`define PLANE_COUNT 6

`define NUM_CONTEXTS 9
`define QUEUE_DEPTH 8

// LL neighbor weights, L is the window column and R the input row
`define W_L0_R0 8
`define W_L1_R0 14
`define W_L2_R0 9
`define W_L0_R1 15
`define W_L2_R1 15
`define W_L0_R2 10
`define W_L1_R2 14
`define W_L2_R2 8

// inclusive upper sum bound of contexts 0 to 7, context 8 takes the rest
`define CTX_BOUND_0 16
`define CTX_BOUND_1 26
`define CTX_BOUND_2 35
`define CTX_BOUND_3 43
`define CTX_BOUND_4 50
`define CTX_BOUND_5 58
`define CTX_BOUND_6 67
`define CTX_BOUND_7 77

`endif

/* context_pkg.sv */
`include "context_params.svh"

package context_pkg;

	typedef logic [`SAMPLE_W-1:0] sample_t;

	// one input column, three rows of the subband
	typedef struct packed {
		sample_t row0;
		sample_t row1;
		sample_t row2;
	} column_t;

	// line0 is the oldest column, line1 holds the center sample
	typedef struct packed {
		column_t line0;
		column_t line1;
		column_t line2;
	} window_t;

	typedef logic [`SUM_W-1:0] sum_t;

	// index 0 is plane 3
	typedef sum_t [`PLANE_COUNT-1:0] plane_sums_t;
	typedef logic [`PLANE_COUNT-1:0] plane_bits_t;

	// one bit per context queue
	typedef logic [`NUM_CONTEXTS-1:0] ctx_vec_t;

	typedef enum logic [2:0] {
		IDLE,
		READ0,
		CALCULATE,
		DISTRIBUTION,
		READ1,
		WAITEMPTY
	} code_state_e;

endpackage

/* neighbor_window.sv */
`timescale 1ns/100ps

module neighbor_window (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 shift,
	input  context_pkg::column_t column_in,
	output context_pkg::window_t window
);

	// three-column shift register, newest column enters at line2
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			window <= '0;
		end else if (shift) begin
			window.line0 <= window.line1;
			window.line1 <= window.line2;
			window.line2 <= column_in;
		end
	end

endmodule

/* context_sum.sv */
`timescale 1ns/100ps
`include "context_params.svh"

module context_sum (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     calc,
	input  context_pkg::window_t     window,
	output context_pkg::plane_sums_t sums,
	output context_pkg::plane_bits_t center_bits
);

	localparam int IDX_W = $clog2(`SAMPLE_W);

	// weighted count of set bits among the eight neighbors of the center
	function automatic context_pkg::sum_t plane_sum(
		input context_pkg::window_t w,
		input logic [IDX_W-1:0]     b
	);
		context_pkg::sum_t s;
		s = '0;
		if (w.line0.row0[b])
			s += `SUM_W'(`W_L0_R0);
		if (w.line1.row0[b])
			s += `SUM_W'(`W_L1_R0);
		if (w.line2.row0[b])
			s += `SUM_W'(`W_L2_R0);
		if (w.line0.row1[b])
			s += `SUM_W'(`W_L0_R1);
		if (w.line2.row1[b])
			s += `SUM_W'(`W_L2_R1);
		if (w.line0.row2[b])
			s += `SUM_W'(`W_L0_R2);
		if (w.line1.row2[b])
			s += `SUM_W'(`W_L1_R2);
		if (w.line2.row2[b])
			s += `SUM_W'(`W_L2_R2);
		return s;
	endfunction

	// all six planes are captured together, the classifier walks them later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sums        <= '0;
			center_bits <= '0;
		end else if (calc) begin
			for (int p = 0; p < `PLANE_COUNT; p++) begin
				sums[p]        <= plane_sum(window, IDX_W'(`FIRST_PLANE + p));
				center_bits[p] <= window.line1.row1[IDX_W'(`FIRST_PLANE + p)];
			end
		end
	end

endmodule

/* context_classifier.sv */
`timescale 1ns/100ps
`include "context_params.svh"

module context_classifier (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     distribute,
	input  logic                     restart,
	input  context_pkg::plane_sums_t sums,
	input  context_pkg::plane_bits_t center_bits,
	output context_pkg::ctx_vec_t    wr,
	output logic                     wr_bit,
	output logic                     last_plane
);

	localparam int PLANE_W = $clog2(`PLANE_COUNT);

	logic [PLANE_W-1:0] plane;
	context_pkg::sum_t  cur_sum;
	context_pkg::ctx_vec_t ctx_sel;

	// plane counter, 0 stands for bit plane 3
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			plane <= '0;
		end else if (restart) begin
			plane <= '0;
		end else if (distribute) begin
			plane <= plane + 1'b1;
		end
	end

	assign cur_sum    = sums[plane];
	assign wr_bit     = center_bits[plane];
	assign last_plane = plane == PLANE_W'(`PLANE_COUNT - 1);

	// threshold ladder, first bound that holds the sum wins
	always_comb begin
		ctx_sel = '0;
		if (cur_sum <= `SUM_W'(`CTX_BOUND_0))
			ctx_sel[0] = 1'b1;
		else if (cur_sum <= `SUM_W'(`CTX_BOUND_1))
			ctx_sel[1] = 1'b1;
		else if (cur_sum <= `SUM_W'(`CTX_BOUND_2))
			ctx_sel[2] = 1'b1;
		else if (cur_sum <= `SUM_W'(`CTX_BOUND_3))
			ctx_sel[3] = 1'b1;
		else if (cur_sum <= `SUM_W'(`CTX_BOUND_4))
			ctx_sel[4] = 1'b1;
		else if (cur_sum <= `SUM_W'(`CTX_BOUND_5))
			ctx_sel[5] = 1'b1;
		else if (cur_sum <= `SUM_W'(`CTX_BOUND_6))
			ctx_sel[6] = 1'b1;
		else if (cur_sum <= `SUM_W'(`CTX_BOUND_7))
			ctx_sel[7] = 1'b1;
		else
			ctx_sel[8] = 1'b1;
	end

	// one strobe per distribute cycle, queues write on the same edge
	assign wr = distribute ? ctx_sel : '0;

endmodule

/* coding_queue.sv */
`timescale 1ns/100ps
`include "context_params.svh"

module coding_queue (
	input  logic clk,
	input  logic rst_n,
	input  logic wr,
	input  logic wr_bit,
	input  logic pop,
	output logic head,
	output logic full,
	output logic empty
);

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);

	logic [`QUEUE_DEPTH-1:0] mem;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_write;
	logic             do_pop;

	// a pop on an empty queue is dropped
	assign do_write = wr && !full;
	assign do_pop   = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= wr_bit;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write)
				wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_write, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// fall-through head, valid while not empty
	assign head  = mem[rd_ptr];
	assign full  = count == (PTR_W + 1)'(`QUEUE_DEPTH);
	assign empty = count == '0;

endmodule

/* encoder_control.sv */
`timescale 1ns/100ps

module encoder_control (
	input  logic clk,
	input  logic rst_n,
	input  logic cal_flag,
	input  logic any_full,
	input  logic all_empty,
	input  logic last_plane,
	output logic shift,
	output logic calc,
	output logic distribute,
	output logic restart,
	output logic column_request
);

	context_pkg::code_state_e state;
	context_pkg::code_state_e next_state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= context_pkg::IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			context_pkg::IDLE:
				next_state = context_pkg::READ0;
			// only the first column waits for cal_flag
			context_pkg::READ0:
				if (cal_flag)
					next_state = context_pkg::CALCULATE;
			context_pkg::CALCULATE:
				next_state = context_pkg::DISTRIBUTION;
			// a full queue blocks the write, the same plane is retried later
			context_pkg::DISTRIBUTION:
				if (any_full)
					next_state = context_pkg::WAITEMPTY;
				else if (last_plane)
					next_state = context_pkg::READ1;
			context_pkg::READ1:
				next_state = context_pkg::CALCULATE;
			context_pkg::WAITEMPTY:
				if (all_empty)
					next_state = context_pkg::DISTRIBUTION;
			default:
				next_state = context_pkg::IDLE;
		endcase
	end

	// window samples on every edge into a read state
	assign shift = (next_state == context_pkg::READ0) || (next_state == context_pkg::READ1);
	assign calc  = next_state == context_pkg::CALCULATE;

	// tells the source the captured column is taken
	assign column_request = next_state == context_pkg::CALCULATE;

	// write only when this cycle does not divert to WAITEMPTY
	assign distribute = (state == context_pkg::DISTRIBUTION) &&
		(next_state != context_pkg::WAITEMPTY);

	// plane counter idles at zero outside of coding
	assign restart = (next_state != context_pkg::DISTRIBUTION) &&
		(next_state != context_pkg::WAITEMPTY);

endmodule

/* context_encoder.sv */
`timescale 1ns/100ps
`include "context_params.svh"

module context_encoder (
	input  logic                  clk,
	input  logic                  rst_n,
	input  context_pkg::column_t  column_in,
	input  logic                  cal_flag,
	input  context_pkg::ctx_vec_t queue_pop,
	output logic                  column_request,
	output context_pkg::ctx_vec_t queue_bit,
	output context_pkg::ctx_vec_t queue_empty,
	output context_pkg::ctx_vec_t queue_full
);

	logic                     shift;
	logic                     calc;
	logic                     distribute;
	logic                     restart;
	logic                     wr_bit;
	logic                     last_plane;
	context_pkg::window_t     window;
	context_pkg::plane_sums_t sums;
	context_pkg::plane_bits_t center_bits;
	context_pkg::ctx_vec_t    wr;

	// back-pressure summary for the FSM
	wire any_full  = |queue_full;
	wire all_empty = &queue_empty;

	encoder_control u_encoder_control (
		.clk            (clk),
		.rst_n          (rst_n),
		.cal_flag       (cal_flag),
		.any_full       (any_full),
		.all_empty      (all_empty),
		.last_plane     (last_plane),
		.shift          (shift),
		.calc           (calc),
		.distribute     (distribute),
		.restart        (restart),
		.column_request (column_request)
	);

	neighbor_window u_neighbor_window (
		.clk       (clk),
		.rst_n     (rst_n),
		.shift     (shift),
		.column_in (column_in),
		.window    (window)
	);

	context_sum u_context_sum (
		.clk         (clk),
		.rst_n       (rst_n),
		.calc        (calc),
		.window      (window),
		.sums        (sums),
		.center_bits (center_bits)
	);

	context_classifier u_context_classifier (
		.clk         (clk),
		.rst_n       (rst_n),
		.distribute  (distribute),
		.restart     (restart),
		.sums        (sums),
		.center_bits (center_bits),
		.wr          (wr),
		.wr_bit      (wr_bit),
		.last_plane  (last_plane)
	);

	// one bit queue per context, all share the data bit
	for (genvar i = 0; i < `NUM_CONTEXTS; i++) begin : g_queue
		coding_queue u_coding_queue (
			.clk    (clk),
			.rst_n  (rst_n),
			.wr     (wr[i]),
			.wr_bit (wr_bit),
			.pop    (queue_pop[i]),
			.head   (queue_bit[i]),
			.full   (queue_full[i]),
			.empty  (queue_empty[i])
		);
	end

endmodule

/* context_encoder_assert.sv */
`timescale 1ns/100ps

module context_encoder_assert (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  cal_flag,
	input logic                  column_request,
	input context_pkg::ctx_vec_t wr,
	input context_pkg::ctx_vec_t queue_full
);

	int unsigned error_count = 0;
	logic        cal_seen;
	logic [2:0]  gap;

	// cycles since the last column request, saturates at 7
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cal_seen <= 1'b0;
			gap      <= 3'd7;
		end else begin
			if (cal_flag)
				cal_seen <= 1'b1;
			if (column_request)
				gap <= '0;
			else if (gap != 3'd7)
				gap <= gap + 1'b1;
		end
	end

	wr_one_hot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wr))
		else begin
			$error("more than one context queue written in one cycle");
			error_count++;
		end

	no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		(queue_full != '0) |-> (wr == '0))
		else begin
			$error("queue written while a queue was full");
			error_count++;
		end

	request_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		column_request |-> (gap == 3'd7))
		else begin
			$error("column request less than 8 cycles after the previous one");
			error_count++;
		end

	// nothing may happen before the first cal_flag
	quiet_before_cal: assert property (@(posedge clk) disable iff (!rst_n)
		(!cal_seen && !cal_flag) |-> (!column_request && wr == '0))
		else begin
			$error("column request or write before cal_flag");
			error_count++;
		end

endmodule

/* context_encoder_tb.sv */
`timescale 1ns/100ps
`include "context_params.svh"

module context_encoder_tb;

	localparam int RESET_CYCLES  = 16;
	localparam int NUM_COLUMNS   = 40;
	localparam int STARVE_START  = 14;
	localparam int STARVE_CYCLES = 120;
	localparam int DRAIN_CYCLES  = 200;
	localparam int CYCLE_LIMIT   =
		(NUM_COLUMNS * 8 + RESET_CYCLES + STARVE_CYCLES + DRAIN_CYCLES) * 2;
	localparam int POP_NONE   = 0;
	localparam int POP_ALL    = 1;
	localparam int POP_RANDOM = 2;

	logic                  clk;
	logic                  rst_n;
	context_pkg::column_t  column_in;
	logic                  cal_flag;
	context_pkg::ctx_vec_t queue_pop;
	logic                  column_request;
	context_pkg::ctx_vec_t queue_bit;
	context_pkg::ctx_vec_t queue_empty;
	context_pkg::ctx_vec_t queue_full;

	// bit 0 is the coded bit, bit 1 marks one of the counted columns
	logic [1:0]           exp_q [`NUM_CONTEXTS][$];
	context_pkg::window_t model_win;
	context_pkg::column_t cur_col;
	logic [15:0]          lfsr_state = 16'd88;
	int                   pop_mode = POP_NONE;
	int                   columns_taken = 0;
	int                   pending_bits = 0;
	int                   cycle_count = 0;
	context_pkg::ctx_vec_t saw_full;
	logic                 saw_all_empty;
	logic                 saw_request;
	context_pkg::ctx_vec_t prev_empty;
	context_pkg::ctx_vec_t full_at_stall;
	int                   stall_pops [`NUM_CONTEXTS];
	logic                 in_stall = 1'b0;

	context_encoder u_context_encoder (.*);

	bind context_encoder context_encoder_assert u_context_encoder_assert (
		.clk(clk), .rst_n(rst_n), .cal_flag(cal_flag), .column_request(column_request),
		.wr(wr), .queue_full(queue_full));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
			report_failure($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic context_pkg::column_t random_column();
		context_pkg::column_t c;
		int i;
		for (i = 0; i < 3 * `SAMPLE_W; i++)
			c[i] = next_random_bit();
		return c;
	endfunction

	// neighbor weights by window column and row, center sample carries none
	function automatic int expected_context(input context_pkg::window_t w, input int plane);
		int weight [3][3];
		int bound [8];
		logic nb [3][3];
		int total;
		int ctx;
		int l;
		int r;
		weight[0] = '{`W_L0_R0, `W_L0_R1, `W_L0_R2};
		weight[1] = '{`W_L1_R0, 0, `W_L1_R2};
		weight[2] = '{`W_L2_R0, `W_L2_R1, `W_L2_R2};
		bound = '{`CTX_BOUND_0, `CTX_BOUND_1, `CTX_BOUND_2, `CTX_BOUND_3,
			`CTX_BOUND_4, `CTX_BOUND_5, `CTX_BOUND_6, `CTX_BOUND_7};
		nb[0] = '{w.line0.row0[plane], w.line0.row1[plane], w.line0.row2[plane]};
		nb[1] = '{w.line1.row0[plane], w.line1.row1[plane], w.line1.row2[plane]};
		nb[2] = '{w.line2.row0[plane], w.line2.row1[plane], w.line2.row2[plane]};
		total = 0;
		for (l = 0; l < 3; l++)
			for (r = 0; r < 3; r++)
				if (nb[l][r])
					total += weight[l][r];
		// context is the number of bounds the sum lies above
		ctx = 0;
		for (l = 0; l < 8; l++)
			if (total > bound[l])
				ctx = l + 1;
		return ctx;
	endfunction

	// sample at the falling edge, drive at the next rising edge
	task automatic run_cycle();
		context_pkg::ctx_vec_t pops;
		logic [1:0] entry;
		logic counted;
		int i;
		int ctx;
		@(negedge clk);
		assert (u_context_encoder.u_context_encoder_assert.error_count == 0)
			else report_failure("a bound assertion on the DUT failed");
		saw_full      = queue_full;
		saw_all_empty = &queue_empty;
		saw_request   = column_request;
		// stalled FSM writes nothing until every queue has drained
		if (in_stall) begin
			assert ((prev_empty & ~queue_empty) == '0)
				else report_failure($sformatf(
					"MISMATCH at %0t: queue written before all drained, empty %b",
					$time, queue_empty));
			if (saw_all_empty) begin
				for (i = 0; i < `NUM_CONTEXTS; i++) begin
					if (full_at_stall[i]) begin
						assert (stall_pops[i] == `QUEUE_DEPTH)
							else report_failure($sformatf(
								"MISMATCH at %0t: full queue %0d held %0d bits, expected %0d",
								$time, i, stall_pops[i], `QUEUE_DEPTH));
					end
				end
				in_stall = 1'b0;
			end
		end
		prev_empty = queue_empty;
		for (i = 0; i < `NUM_CONTEXTS; i++) begin
			if (queue_pop[i] && !queue_empty[i]) begin
				assert (exp_q[i].size() != 0)
					else report_failure($sformatf("queue %0d gave a bit nobody expected", i));
				entry = exp_q[i].pop_front();
				assert (queue_bit[i] == entry[0])
					else report_failure($sformatf("MISMATCH at %0t: queue %0d bit %0b, expected %0b",
						$time, i, queue_bit[i], entry[0]));
				if (entry[1])
					pending_bits--;
				if (in_stall)
					stall_pops[i]++;
			end
		end
		// calc on the coming edge sees the column shifted in since the last one
		if (column_request) begin
			if (columns_taken == 0) begin
				model_win.line0 = cur_col;
				model_win.line1 = cur_col;
			end else begin
				model_win.line0 = model_win.line1;
				model_win.line1 = model_win.line2;
			end
			model_win.line2 = cur_col;
			counted = columns_taken < NUM_COLUMNS;
			for (i = 0; i < `PLANE_COUNT; i++) begin
				ctx = expected_context(model_win, `FIRST_PLANE + i);
				exp_q[ctx].push_back({counted, model_win.line1.row1[`FIRST_PLANE + i]});
				if (counted)
					pending_bits++;
			end
			columns_taken++;
			if (columns_taken < NUM_COLUMNS)
				cur_col = random_column();
		end
		for (i = 0; i < `NUM_CONTEXTS; i++) begin
			case (pop_mode)
				POP_ALL:    pops[i] = 1'b1;
				POP_RANDOM: pops[i] = next_random_bit();
				default:    pops[i] = 1'b0;
			endcase
		end
		@(posedge clk);
		column_in <= cur_col;
		queue_pop <= pops;
	endtask

	initial begin
		int starve;
		rst_n     = 1'b0;
		cal_flag  = 1'b0;
		queue_pop = '0;
		cur_col   = random_column();
		column_in = cur_col;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		// pops on empty queues while the FSM still waits for cal_flag
		pop_mode = POP_ALL;
		repeat (8) begin
			run_cycle();
			assert (saw_all_empty && !saw_request)
				else report_failure($sformatf("MISMATCH at %0t: queue data or request before cal_flag",
					$time));
		end
		cal_flag <= 1'b1;
		pop_mode = POP_RANDOM;
		while (columns_taken < STARVE_START)
			run_cycle();
		// hold pops off until some queue fills and the FSM stalls
		pop_mode = POP_NONE;
		starve = 0;
		saw_full = '0;
		while (saw_full == '0) begin
			assert (starve < STARVE_CYCLES)
				else report_failure("no queue became full while pops were held off");
			run_cycle();
			starve++;
		end
		// a full queue holds exactly QUEUE_DEPTH bits until the stall ends
		full_at_stall = saw_full;
		stall_pops    = '{default: 0};
		in_stall      = 1'b1;
		repeat (8) run_cycle();
		pop_mode = POP_RANDOM;
		while (columns_taken < NUM_COLUMNS)
			run_cycle();
		// later columns repeat the last input and are not counted
		pop_mode = POP_ALL;
		saw_all_empty = 1'b0;
		while (pending_bits != 0 || !saw_all_empty)
			run_cycle();
		@(negedge clk);
		if (u_context_encoder.u_context_encoder_assert.error_count == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			report_failure("a bound assertion on the DUT failed near the end of the run");
		end
	end

endmodule

/* sim.f */
+incdir+.
context_pkg.sv
neighbor_window.sv
context_sum.sv
context_classifier.sv
coding_queue.sv
encoder_control.sv
context_encoder.sv
context_encoder_assert.sv
context_encoder_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the context encoder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	--top-module context_encoder_tb \
	-f sim.f
./obj_dir/Vcontext_encoder_tb +verilator+error+limit+100
